/* branch_unit_top.f */
verilog/arch_pkg.sv
verilog/isa_pkg.sv
verilog/resolve_if.sv
verilog/branch_eval.sv
verilog/cond_reg_file.sv
verilog/loop_counter.sv
verilog/branch_resolve.sv
verilog/branch_unit_top.sv
sim/tb_clock_gen.sv
sim/branch_unit_tb.sv

/* Makefile */
# Verilator build and run of the branch unit testbench

VERILATOR ?= verilator
FILELIST  ?= branch_unit_top.f
TB_TOP    ?= branch_unit_tb
RTL_TOP   ?= branch_unit_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
COMMON    ?= --timing --timescale 1ns/10ps
VFLAGS    ?= --binary --assert -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(COMMON) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(COMMON) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sim/branch_unit_tb.sv */
`timescale 1ns/10ps

module branch_unit_tb;
	import arch_pkg::*;
	import isa_pkg::*;

	// Instruction slots of the directed part and of the random part
	localparam int N_DIRECTED = 150;
	localparam int N_RANDOM = 500;
	localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 4 + 100;

	// One predicted result of the resolve stage
	typedef struct packed {
		logic taken;
		address_t target;
		logic dec;
	} expect_t;

	logic clk;
	logic rst_n;
	operating_mode_t om;
	logic in_valid;
	instruction_t instr;
	address_t pc;
	logic cr_we;
	cr_sel_t cr_wsel;
	logic cr_wbit;
	logic lc_we;
	value_t lc_wdata;
	logic out_valid;
	logic taken;
	address_t target;
	value_t lc_value;

	// Reference copies of the architectural state
	cond_reg_t ref_cr;
	value_t ref_lc;
	logic dec_pending;
	expect_t outstanding[$];
	logic [31:0] rng;

	tb_clock_gen u_clk (.clk(clk));

	branch_unit_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.om(om),
		.in_valid(in_valid),
		.instr(instr),
		.pc(pc),
		.cr_we(cr_we),
		.cr_wsel(cr_wsel),
		.cr_wbit(cr_wbit),
		.lc_we(lc_we),
		.lc_wdata(lc_wdata),
		.out_valid(out_valid),
		.taken(taken),
		.target(target),
		.lc_value(lc_value)
	);

	// ==========================================================
	// Error reporting and compare tasks
	// ==========================================================

	task automatic report_error(string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic compare_bit(string what, logic got, logic exp);
		if (got !== exp)
			report_error($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic compare_address(string what, address_t got, address_t exp);
		if (got !== exp)
			report_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic compare_value(string what, value_t got, value_t exp);
		if (got !== exp)
			report_error($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// ==========================================================
	// Random source and instruction builders
	// ==========================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			rng = lfsr_step(rng);
			r = {r[62:0], rng[0]};
		end
		return r;
	endfunction

	function automatic instruction_t make_bcc(opcode_t opc, cond_t cc, logic [2:0] crf,
			logic [11:0] sd);
		return {sd, crf, 6'd0, cc, 1'b0, opc};
	endfunction

	function automatic instruction_t make_b(opcode_t opc, logic [24:0] ld);
		return {ld, opc};
	endfunction

	// ==========================================================
	// Reference model
	// ==========================================================

	// Decision, next fetch address and count-down straight from the code table
	function automatic expect_t predict(instruction_t ins, address_t p, logic crb, value_t lc);
		expect_t e;
		logic [6:0] opc;
		logic [2:0] cc;
		logic nz;
		logic signed [63:0] off;
		opc = ins[6:0];
		cc = ins[10:8];
		nz = (lc != 64'd0);
		e.taken = 1'b0;
		e.dec = 1'b0;
		off = 64'($signed(ins[31:20]));
		if (opc == OP_B0 || opc == OP_B1) begin
			e.taken = 1'b1;
			off = 64'($signed(ins[31:7]));
		end else if (opc == OP_BCC0 || opc == OP_BCC1) begin
			case (cc)
				3'd0: e.taken = nz && !crb;
				3'd1: e.taken = !nz && !crb;
				3'd2: e.taken = !crb;
				3'd3: e.taken = nz && crb;
				3'd4: e.taken = !nz && crb;
				3'd5: e.taken = crb;
				3'd6: e.taken = nz;
				default: e.taken = !nz;
			endcase
			e.dec = (cc != 3'd2) && (cc != 3'd5);
		end
		e.target = e.taken ? p + address_t'(off * 64'sd4) : p + 64'd4;
		return e;
	endfunction

	// Checks last cycle's result first, then predicts and steps the state
	always @(posedge clk) begin
		expect_t e;
		logic new_dec;
		if (!rst_n) begin
			ref_cr = '0;
			ref_lc = '0;
			dec_pending = 1'b0;
			outstanding.delete();
		end else begin
			if (outstanding.size() > 0) begin
				e = outstanding.pop_front();
				compare_bit("out_valid", out_valid, 1'b1);
				compare_bit("taken", taken, e.taken);
				compare_address("target", target, e.target);
			end else begin
				compare_bit("out_valid", out_valid, 1'b0);
			end
			compare_value("lc_value", lc_value, ref_lc);
			new_dec = 1'b0;
			if (in_valid) begin
				e = predict(instr, pc, ref_cr[{om, instr[19:17]}], ref_lc);
				outstanding.push_back(e);
				new_dec = e.dec;
			end
			if (cr_we)
				ref_cr[cr_wsel] = cr_wbit;
			// Load beats the count-down of the previous resolved branch
			if (lc_we)
				ref_lc = lc_wdata;
			else if (dec_pending && ref_lc != 64'd0)
				ref_lc = ref_lc - 64'd1;
			dec_pending = new_dec;
		end
	end

	// ==========================================================
	// Stimulus
	// ==========================================================

	task automatic drive_cycle(logic iv, instruction_t ins, address_t p, operating_mode_t m,
			logic cwe, cr_sel_t csel, logic cbit, logic lwe, value_t ldata);
		@(posedge clk);
		in_valid <= iv;
		instr <= ins;
		pc <= p;
		om <= m;
		cr_we <= cwe;
		cr_wsel <= csel;
		cr_wbit <= cbit;
		lc_we <= lwe;
		lc_wdata <= ldata;
	endtask

	task automatic send_instr(instruction_t ins, address_t p, operating_mode_t m);
		drive_cycle(1'b1, ins, p, m, 1'b0, '0, 1'b0, 1'b0, '0);
	endtask

	task automatic write_cond_bit(cr_sel_t sel, logic b);
		drive_cycle(1'b0, '0, '0, 2'd0, 1'b1, sel, b, 1'b0, '0);
	endtask

	task automatic load_counter(value_t v);
		drive_cycle(1'b0, '0, '0, 2'd0, 1'b0, '0, 1'b0, 1'b1, v);
	endtask

	initial begin
		int b;
		int z;
		int c;
		int m;
		int q;
		int n;
		opcode_t r_opc;
		rng = 32'h1f47_b349;
		rst_n = 1'b0;
		om = '0;
		in_valid = 1'b0;
		instr = '0;
		pc = '0;
		cr_we = 1'b0;
		cr_wsel = '0;
		cr_wbit = 1'b0;
		lc_we = 1'b0;
		lc_wdata = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// Every code against bit 3 of bank 0, with the counter at zero and far from it
		for (b = 0; b < 2; b++) begin
			write_cond_bit(5'd3, 1'(b));
			for (z = 0; z < 2; z++) begin
				load_counter((z == 0) ? 64'd100 : 64'd0);
				for (c = 0; c < 8; c++)
					send_instr(make_bcc(OP_BCC0, 3'(c), 3'd3, 12'd8), 64'h2000, 2'd0);
			end
		end

		// Unconditional branches, then other opcodes that carry counting codes
		load_counter(64'd5);
		send_instr(make_b(OP_B0, 25'd3), 64'h4000, 2'd1);
		send_instr(make_b(OP_B1, 25'd3), 64'h4000, 2'd2);
		send_instr(make_bcc(7'd0, 3'd6, 3'd0, 12'd1), 64'h4000, 2'd0);
		send_instr(make_bcc(7'd19, 3'd0, 3'd0, 12'd1), 64'h4000, 2'd0);
		send_instr(make_bcc(7'd42, 3'd7, 3'd0, 12'd1), 64'h4000, 2'd0);
		send_instr(make_bcc(7'h7f, 3'd1, 3'd0, 12'd1), 64'h4000, 2'd0);

		// Forward and backward displacements and the fall-through path
		send_instr(make_b(OP_B0, 25'd5), 64'h1000, 2'd0);
		send_instr(make_b(OP_B1, 25'h1ff_fff9), 64'h1000, 2'd0);
		send_instr(make_b(OP_B0, 25'h100_0000), 64'h8000_0000, 2'd0);
		send_instr(make_b(OP_B1, 25'h0ff_ffff), 64'h0, 2'd0);
		send_instr(make_bcc(OP_BCC1, CC_CLR, 3'd7, 12'd100), 64'h3000, 2'd3);
		send_instr(make_bcc(OP_BCC0, CC_CLR, 3'd7, 12'h800), 64'h3000, 2'd3);
		send_instr(make_bcc(OP_BCC1, CC_CLR, 3'd7, 12'hfff), 64'h0, 2'd3);
		send_instr(make_bcc(OP_BCC0, CC_SET, 3'd7, 12'd100), 64'hffff_ffff_ffff_fffc, 2'd3);

		// One bit set in one bank must not show through in the other banks
		for (m = 0; m < 4; m++) begin
			write_cond_bit(5'(m * 8 + 6), 1'b1);
			for (q = 0; q < 4; q++)
				send_instr(make_bcc(OP_BCC0, CC_SET, 3'd6, 12'd2), 64'h5000, 2'(q));
			write_cond_bit(5'(m * 8 + 6), 1'b0);
		end

		// Back-to-back counting branches run the counter into zero
		load_counter(64'd3);
		for (n = 0; n < 6; n++)
			send_instr(make_bcc(OP_BCC1, CC_NZ, 3'd0, 12'h7fc), 64'h6000, 2'd0);
		// Count-down and load on the same edge, then a load beside an instruction
		send_instr(make_bcc(OP_BCC0, CC_Z, 3'd0, 12'd4), 64'h6000, 2'd0);
		load_counter(64'd9);
		send_instr(make_bcc(OP_BCC0, CC_NZ, 3'd0, 12'd4), 64'h6000, 2'd0);
		drive_cycle(1'b1, make_bcc(OP_BCC1, CC_NZ_CLR, 3'd0, 12'd4), 64'h6000, 2'd0,
			1'b0, '0, 1'b0, 1'b1, 64'd1);
		send_instr(make_bcc(OP_BCC0, CC_NZ, 3'd0, 12'd4), 64'h6000, 2'd0);
		send_instr(make_bcc(OP_BCC0, CC_Z, 3'd0, 12'd4), 64'h6000, 2'd0);

		// Random mix of instructions, bit writes and counter loads
		for (n = 0; n < N_RANDOM; n++) begin
			case (2'(rand_bits(2)))
				2'd0: r_opc = rand_bits(1) != 64'd0 ? OP_B1 : OP_B0;
				2'd1, 2'd2: r_opc = rand_bits(1) != 64'd0 ? OP_BCC1 : OP_BCC0;
				default: r_opc = opcode_t'(rand_bits(7));
			endcase
			drive_cycle(2'(rand_bits(2)) != 2'd0, {25'(rand_bits(25)), r_opc},
				address_t'(rand_bits(64)), operating_mode_t'(rand_bits(2)),
				2'(rand_bits(2)) == 2'd0, cr_sel_t'(rand_bits(5)), 1'(rand_bits(1)),
				3'(rand_bits(3)) == 3'd0, value_t'(rand_bits(4)));
		end
		drive_cycle(1'b0, '0, '0, 2'd0, 1'b0, '0, 1'b0, 1'b0, '0);

		// Drain the results still in flight
		@(posedge clk);
		while (outstanding.size() != 0)
			@(posedge clk);
		$display("PASS: all tests");
		$finish;
	end

	// The run must be over well before this many cycles
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_error($sformatf("Timeout after %0d cycles, the run did not finish",
			WATCHDOG_CYCLES));
	end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps

// Free-running clock for the testbench
module tb_clock_gen (
	output logic clk
);
	// Half of the 40 ns period
	localparam realtime HALF_PERIOD = 20ns;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

/* verilog/branch_unit_top.sv */
`timescale 1ns/10ps

module branch_unit_top (
	input logic clk,
	input logic rst_n,
	input arch_pkg::operating_mode_t om,
	input logic in_valid,
	input isa_pkg::instruction_t instr,
	input arch_pkg::address_t pc,
	input logic cr_we,
	input arch_pkg::cr_sel_t cr_wsel,
	input logic cr_wbit,
	input logic lc_we,
	input arch_pkg::value_t lc_wdata,
	output logic out_valid,
	output logic taken,
	output arch_pkg::address_t target,
	output arch_pkg::value_t lc_value
);
	import isa_pkg::*;

	logic cr_bit;

	resolve_if res_bus ();

	// ==========================================================
	// State blocks
	// ==========================================================

	// The field of the instruction goes straight to the register read
	cond_reg_file u_cr (
		.clk(clk),
		.rst_n(rst_n),
		.we(cr_we),
		.wsel(cr_wsel),
		.wbit(cr_wbit),
		.om(om),
		.crf(instr[CRF_LSB +: CRF_W]),
		.rbit(cr_bit),
		.cr()
	);

	loop_counter u_lc (
		.clk(clk),
		.rst_n(rst_n),
		.we(lc_we),
		.wdata(lc_wdata),
		.res(res_bus),
		.lc(lc_value)
	);

	// ==========================================================
	// Resolve stage
	// ==========================================================

	branch_resolve u_resolve (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.instr(instr),
		.pc(pc),
		.cr_bit(cr_bit),
		.lc(lc_value),
		.res(res_bus)
	);

	// Resolved branch out to the core
	assign out_valid = res_bus.valid;
	assign taken = res_bus.taken;
	assign target = res_bus.target;

endmodule

/* verilog/branch_resolve.sv */
`timescale 1ns/10ps

module branch_resolve (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input isa_pkg::instruction_t instr,
	input arch_pkg::address_t pc,
	input logic cr_bit,
	input arch_pkg::value_t lc,
	resolve_if.source res
);
	import arch_pkg::*;
	import isa_pkg::*;

	opcode_t opc;
	logic is_long;
	logic takb;
	logic is_count;
	address_t disp_words;
	address_t branch_addr;
	address_t fall_addr;

	branch_eval u_eval (
		.instr(instr),
		.cr_bit(cr_bit),
		.lc(lc),
		.takb(takb),
		.is_count(is_count)
	);

	// ==========================================================
	// Target address
	// ==========================================================

	assign opc = instr[OPC_LSB +: OPC_W];
	// Unconditional branches carry the long displacement
	assign is_long = (opc == OP_B0) || (opc == OP_B1);

	// Sign-extend the displacement in words to the full address width
	always_comb begin
		if (is_long) begin
			disp_words = {{(64 - LDISP_W){instr[LDISP_LSB + LDISP_W - 1]}},
				instr[LDISP_LSB +: LDISP_W]};
		end else begin
			disp_words = {{(64 - SDISP_W){instr[SDISP_LSB + SDISP_W - 1]}},
				instr[SDISP_LSB +: SDISP_W]};
		end
	end

	// Word counts become byte offsets by the instruction size
	assign branch_addr = pc + disp_words * address_t'(INSTR_BYTES);
	assign fall_addr = pc + address_t'(INSTR_BYTES);

	// ==========================================================
	// Result registers
	// ==========================================================

	// Control strobes clear on reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res.valid <= 1'b0;
			res.count_dec <= 1'b0;
		end else begin
			res.valid <= in_valid;
			res.count_dec <= in_valid && is_count;
		end
	end

	// Decision and target are only meaningful with valid
	always_ff @(posedge clk) begin
		if (in_valid) begin
			res.taken <= takb;
			res.target <= takb ? branch_addr : fall_addr;
		end
	end

	// Nothing may resolve in the cycle right after reset
	a_quiet_after_reset: assert property (
		@(posedge clk) !rst_n |=> !res.valid
	) else $error("branch_resolve: valid high right after reset");

endmodule

/* verilog/loop_counter.sv */
`timescale 1ns/10ps

module loop_counter (
	input logic clk,
	input logic rst_n,
	input logic we,
	input arch_pkg::value_t wdata,
	resolve_if.sink res,
	output arch_pkg::value_t lc
);
	import arch_pkg::*;

	logic lc_zero;

	assign lc_zero = (lc == '0);

	// ==========================================================
	// Counter update
	// ==========================================================

	// A load from the core wins over a count-down on the same edge
	// The count-down stops at zero so a loop never wraps around
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lc <= '0;
		end else if (we) begin
			lc <= wdata;
		end else if (res.count_dec && !lc_zero) begin
			lc <= lc - value_t'(1);
		end
	end

	// A count-down at zero without a load must leave the counter at zero
	a_no_wrap: assert property (
		@(posedge clk) disable iff (!rst_n)
		(res.count_dec && !we && lc_zero) |=> (lc == '0)
	) else $error("loop_counter: count-down wrapped below zero");

	// The resolve stage only asks for a count-down with a resolved branch
	a_dec_with_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		res.count_dec |-> res.valid
	) else $error("loop_counter: count_dec without valid");

endmodule

/* verilog/cond_reg_file.sv */
`timescale 1ns/10ps

module cond_reg_file (
	input logic clk,
	input logic rst_n,
	input logic we,
	input arch_pkg::cr_sel_t wsel,
	input logic wbit,
	input arch_pkg::operating_mode_t om,
	input logic [2:0] crf,
	output logic rbit,
	output arch_pkg::cond_reg_t cr
);
	import arch_pkg::*;

	cr_sel_t rsel;

	// ==========================================================
	// Register update
	// ==========================================================

	// The core writes one addressed bit per cycle
	// A write lands on the edge and is seen by the next instruction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cr <= '0;
		end else if (we) begin
			cr[wsel] <= wbit;
		end
	end

	// ==========================================================
	// Mode-indexed read
	// ==========================================================

	// The mode picks the bank and the instruction field picks the bit
	assign rsel = {om, crf};
	assign rbit = cr[rsel];

	// An unknown write index would corrupt an unknown bit of some bank
	a_wsel_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		we |-> !$isunknown(wsel)
	) else $error("cond_reg_file: write index unknown while we is high");

endmodule

/* verilog/branch_eval.sv */
`timescale 1ns/10ps

module branch_eval (
	input isa_pkg::instruction_t instr,
	input logic cr_bit,
	input arch_pkg::value_t lc,
	output logic takb,
	output logic is_count
);
	import isa_pkg::*;

	opcode_t opc;
	cond_t cnd;
	logic lc_zero;
	logic is_bcc;

	// ==========================================================
	// Field decode
	// ==========================================================

	assign opc = instr[OPC_LSB +: OPC_W];
	assign cnd = instr[CND_LSB +: CND_W];

	// Most conditions test the counter against zero
	assign lc_zero = (lc == '0);
	assign is_bcc = (opc == OP_BCC0) || (opc == OP_BCC1);

	// ==========================================================
	// Taken decision
	// ==========================================================

	always_comb begin
		case (opc)
			OP_BCC0, OP_BCC1: begin
				// Eight codes mix the counter test and the selected bit
				case (cnd)
					CC_NZ_CLR: takb = !lc_zero && !cr_bit;
					CC_Z_CLR:  takb = lc_zero && !cr_bit;
					CC_CLR:    takb = !cr_bit;
					CC_NZ_SET: takb = !lc_zero && cr_bit;
					CC_Z_SET:  takb = lc_zero && cr_bit;
					CC_SET:    takb = cr_bit;
					CC_NZ:     takb = !lc_zero;
					default:   takb = lc_zero;
				endcase
			end
			// Unconditional branches always go
			OP_B0, OP_B1: takb = 1'b1;
			// Anything that is not a branch falls through
			default: takb = 1'b0;
		endcase
	end

	// Only the two pure bit tests leave the counter alone
	// Non-branch opcodes never count, so the opcode gates the flag here
	always_comb begin
		is_count = is_bcc && (cnd != CC_CLR) && (cnd != CC_SET);
	end

endmodule

/* verilog/resolve_if.sv */
`timescale 1ns/10ps

// One resolved branch as it leaves the resolve stage
interface resolve_if;

	// Pulses for one cycle per accepted instruction
	logic valid;
	// Branch decision of the resolved instruction
	logic taken;
	// Next fetch address, either the branch address or the fall-through
	arch_pkg::address_t target;
	// Asks the loop counter to count down by one
	logic count_dec;

	// The resolve stage produces every field from its registers
	modport source (
		output valid,
		output taken,
		output target,
		output count_dec
	);

	// The state blocks and the top ports only observe
	modport sink (
		input valid,
		input taken,
		input target,
		input count_dec
	);

endinterface

/* verilog/isa_pkg.sv */
package isa_pkg;

	// ==========================================================
	// Instruction word and its fields
	// ==========================================================

	typedef logic [31:0] instruction_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] cond_t;

	// Bit positions of the fields, given as low bit and width
	localparam int unsigned OPC_LSB   = 0;
	localparam int unsigned OPC_W     = 7;
	localparam int unsigned CND_LSB   = 8;
	localparam int unsigned CND_W     = 3;
	localparam int unsigned CRF_LSB   = 17;
	localparam int unsigned CRF_W     = 3;
	// Short displacement of the conditional branches
	localparam int unsigned SDISP_LSB = 20;
	localparam int unsigned SDISP_W   = 12;
	// Long displacement of the unconditional branches
	localparam int unsigned LDISP_LSB = 7;
	localparam int unsigned LDISP_W   = 25;

	// Every instruction is one 32-bit word
	localparam int unsigned INSTR_BYTES = 4;

	// Branch opcodes, two encodings each
	localparam opcode_t OP_B0   = 7'd32;
	localparam opcode_t OP_B1   = 7'd33;
	localparam opcode_t OP_BCC0 = 7'd40;
	localparam opcode_t OP_BCC1 = 7'd41;

	// Condition codes of the conditional branches
	localparam cond_t CC_NZ_CLR = 3'd0;
	localparam cond_t CC_Z_CLR  = 3'd1;
	localparam cond_t CC_CLR    = 3'd2;
	localparam cond_t CC_NZ_SET = 3'd3;
	localparam cond_t CC_Z_SET  = 3'd4;
	localparam cond_t CC_SET    = 3'd5;
	localparam cond_t CC_NZ     = 3'd6;
	localparam cond_t CC_Z      = 3'd7;

endpackage

/* verilog/arch_pkg.sv */
package arch_pkg;

	// ==========================================================
	// Architectural state shared by the whole core
	// ==========================================================

	// A general data value as held in registers
	// The loop counter and its load data use this width
	typedef logic [63:0] value_t;

	// An instruction address in bytes
	// The program counter and every branch target are this wide
	typedef logic [63:0] address_t;

	// Privilege mode of the core
	// Each mode owns one 8-bit bank of the condition register
	typedef logic [1:0] operating_mode_t;

	// The whole condition register with four banks of eight bits
	typedef logic [31:0] cond_reg_t;

	// Index of a single condition register bit
	// The upper two bits are the mode and the lower three pick a bit in the bank
	typedef logic [4:0] cr_sel_t;

endpackage
